// File: extract_pkg.sv
`default_nettype none

package extract_pkg;

	// ====================
	// Widths
	// ====================

	localparam int INS_W = 32;
	localparam int SLOTS = 4;
	localparam int LINE_W = 256;
	localparam int PC_W = 16;
	localparam int OPC_W = 8;
	// One group is half a cache line
	localparam int GRP_W = INS_W * SLOTS;
	localparam int SLOT_IDX_W = $clog2(SLOTS);
	localparam int GRP_BYTES = GRP_W / 8;
	localparam int LINE_BYTES = LINE_W / 8;
	// Address bit that picks the upper or lower half of a line
	localparam int HALF_BIT = $clog2(GRP_BYTES);

	// ====================
	// Encodings
	// ====================

	// Opcode sits in instruction bits 7..0
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 8'h00,
		OP_SYS   = 8'h01,
		OP_ALU   = 8'h02,
		OP_MACRO = 8'h03,
		OP_UOP   = 8'h04
	} opcode_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ,
		ST_ACK_LOW,
		ST_RUN,
		ST_UCODE
	} fetch_state_t;

	// Macro fields, also reused for the entry field of a micro-op
	localparam int MACRO_CNT_LSB = 8;
	localparam int MACRO_CNT_W = 2;
	localparam int MACRO_ENT_LSB = 10;
	localparam int MACRO_ENT_W = 6;

	// Micro-op step and slot fields
	localparam int UOP_STEP_LSB = 16;
	localparam int UOP_SLOT_LSB = 18;

	// Interrupt instruction fields
	localparam int IRQ_VEC_LSB = 8;
	localparam int IRQ_VEC_W = 9;
	localparam int IRQ_LVL_LSB = 17;
	localparam int IRQ_LVL_W = 3;
	localparam int FN_LSB = 20;
	localparam int FN_W = 4;
	localparam logic [FN_W-1:0] FN_IRQ = 4'd1;

	// A no-op is an all-zero word apart from its opcode
	localparam logic [INS_W-1:0] NOP_INS = INS_W'(OP_NOP);

endpackage

`default_nettype wire

// File: fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl import extract_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire                    line_ack_i,
	input  wire                    irq_req_i,
	input  wire                    redirect_i,
	input  wire [PC_W-1:0]         redirect_pc_i,
	input  wire                    en_i,
	input  wire                    uc_busy_i,
	input  wire                    uc_last_i,
	input  wire [MACRO_CNT_W-1:0]  macro_cnt_i,
	output logic                   line_req_o,
	output logic [PC_W-1:0]        line_addr_o,
	output logic                   irq_ack_o,
	output logic                   line_load_o,
	output logic                   emit_o,
	output logic                   sel_irq_o,
	output logic                   sel_uop_o,
	output logic                   half_sel_o,
	output logic [SLOT_IDX_W-1:0]  skip_cnt_o,
	output logic                   uc_start_o,
	output logic [PC_W-1:0]        grp_pc_o
);

	fetch_state_t state;
	fetch_state_t state_nxt;
	// Address of the next group to emit, always 16-byte aligned
	logic [PC_W-1:0] grp_ptr;
	logic [PC_W-1:0] ptr_nxt;
	// Leading slots still to be blanked on the first line group after a redirect
	logic [SLOT_IDX_W-1:0] skip_q;
	// Set when a redirect lands while a line handshake is still open
	logic discard_q;

	assign grp_pc_o = grp_ptr;
	assign half_sel_o = grp_ptr[HALF_BIT];
	assign skip_cnt_o = skip_q;
	// The line is captured on the same edge that the source acknowledges
	assign line_load_o = (state == ST_REQ) && line_ack_i;

	// ====================
	// Next state
	// ====================

	always_comb begin
		state_nxt = state;
		ptr_nxt = grp_ptr;
		emit_o = 1'b0;
		sel_irq_o = 1'b0;
		sel_uop_o = 1'b0;
		uc_start_o = 1'b0;
		case (state)
			ST_IDLE: state_nxt = ST_REQ;
			ST_REQ: begin
				if (line_ack_i)
					state_nxt = ST_ACK_LOW;
			end
			ST_ACK_LOW: begin
				// A stale line is dropped and the new address is fetched instead
				if (!line_ack_i)
					state_nxt = (discard_q || redirect_i) ? ST_REQ : ST_RUN;
			end
			ST_RUN: begin
				if (redirect_i) begin
					state_nxt = ST_REQ;
				end else if (en_i) begin
					emit_o = 1'b1;
					if (irq_req_i && !irq_ack_o) begin
						// Interrupt group takes this slot and the pointer holds
						sel_irq_o = 1'b1;
					end else if (macro_cnt_i != '0) begin
						// Pointer holds on the macro address for the whole run
						uc_start_o = 1'b1;
						state_nxt = ST_UCODE;
					end else begin
						ptr_nxt = grp_ptr + PC_W'(GRP_BYTES);
						if (half_sel_o)
							state_nxt = ST_REQ;
					end
				end
			end
			ST_UCODE: begin
				if (redirect_i) begin
					state_nxt = ST_REQ;
				end else if (!uc_busy_i) begin
					state_nxt = ST_RUN;
				end else if (en_i) begin
					emit_o = 1'b1;
					sel_uop_o = 1'b1;
					// Last step moves on past the macro group
					if (uc_last_i) begin
						ptr_nxt = grp_ptr + PC_W'(GRP_BYTES);
						state_nxt = half_sel_o ? ST_REQ : ST_RUN;
					end
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
		// Redirect overrides every pointer update, rounded down to a group
		if (redirect_i)
			ptr_nxt = redirect_pc_i & ~PC_W'(GRP_BYTES - 1);
	end

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= ST_IDLE;
			grp_ptr <= '0;
			skip_q <= '0;
			discard_q <= 1'b0;
			line_req_o <= 1'b0;
			line_addr_o <= '0;
			irq_ack_o <= 1'b0;
		end else begin
			state <= state_nxt;
			grp_ptr <= ptr_nxt;
			line_req_o <= (state_nxt == ST_REQ);
			// Address is latched once per request and stays put until ack
			if (state_nxt == ST_REQ && state != ST_REQ)
				line_addr_o <= ptr_nxt & ~PC_W'(LINE_BYTES - 1);
			if (state_nxt == ST_REQ && state != ST_REQ)
				discard_q <= 1'b0;
			else if (redirect_i && (state == ST_REQ || state == ST_ACK_LOW))
				discard_q <= 1'b1;
			if (redirect_i)
				skip_q <= redirect_pc_i[HALF_BIT-1 -: SLOT_IDX_W];
			else if (emit_o && !sel_irq_o && !sel_uop_o)
				skip_q <= '0;
			// Ack rises with the interrupt group and falls once req has dropped
			irq_ack_o <= sel_irq_o || (irq_ack_o && irq_req_i);
		end
	end

endmodule

`default_nettype wire

// File: ucode_seq.sv
`timescale 1ns/100ps
`default_nettype none

module ucode_seq import extract_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire                    start_i,
	input  wire                    cancel_i,
	input  wire                    step_i,
	input  wire [MACRO_CNT_W-1:0]  cnt_i,
	input  wire [MACRO_ENT_W-1:0]  ent_i,
	output logic                   busy_o,
	output logic                   last_o,
	output logic [INS_W-1:0]       uop0_o,
	output logic [INS_W-1:0]       uop1_o,
	output logic [INS_W-1:0]       uop2_o,
	output logic [INS_W-1:0]       uop3_o
);

	// Groups still to be emitted for the current macro
	logic [MACRO_CNT_W-1:0] rem_q;
	// Zero-based step of the group on the outputs
	logic [MACRO_CNT_W-1:0] step_q;
	logic [MACRO_ENT_W-1:0] ent_q;

	// Stand-in for a microcode ROM: the word is built from its coordinates
	function automatic logic [INS_W-1:0] form_uop(
		input logic [MACRO_ENT_W-1:0] ent,
		input logic [MACRO_CNT_W-1:0] step,
		input logic [SLOT_IDX_W-1:0]  slot
	);
		form_uop = INS_W'(OP_UOP)
			| (INS_W'(ent) << MACRO_ENT_LSB)
			| (INS_W'(step) << UOP_STEP_LSB)
			| (INS_W'(slot) << UOP_SLOT_LSB);
	endfunction

	assign busy_o = (rem_q != '0);
	assign last_o = (rem_q == MACRO_CNT_W'(1));

	assign uop0_o = form_uop(ent_q, step_q, SLOT_IDX_W'(0));
	assign uop1_o = form_uop(ent_q, step_q, SLOT_IDX_W'(1));
	assign uop2_o = form_uop(ent_q, step_q, SLOT_IDX_W'(2));
	assign uop3_o = form_uop(ent_q, step_q, SLOT_IDX_W'(3));

	// Cancel wins over a new start, start wins over a step
	always_ff @(posedge clk) begin
		if (rst_i || cancel_i) begin
			rem_q <= '0;
			step_q <= '0;
		end else if (start_i) begin
			rem_q <= cnt_i;
			step_q <= '0;
		end else if (step_i && busy_o) begin
			rem_q <= rem_q - MACRO_CNT_W'(1);
			step_q <= step_q + MACRO_CNT_W'(1);
		end
	end

	// Entry only matters while busy
	always_ff @(posedge clk) begin
		if (start_i)
			ent_q <= ent_i;
	end

endmodule

`default_nettype wire

// File: slot_extract.sv
`timescale 1ns/100ps
`default_nettype none

module slot_extract import extract_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire                    line_load_i,
	input  wire [LINE_W-1:0]       line_i,
	input  wire                    emit_i,
	input  wire                    en_i,
	input  wire                    half_sel_i,
	input  wire [SLOT_IDX_W-1:0]   skip_cnt_i,
	input  wire                    sel_irq_i,
	input  wire                    sel_uop_i,
	input  wire [IRQ_VEC_W-1:0]    irq_vec_i,
	input  wire [IRQ_LVL_W-1:0]    irq_lvl_i,
	input  wire [INS_W-1:0]        uop0_i,
	input  wire [INS_W-1:0]        uop1_i,
	input  wire [INS_W-1:0]        uop2_i,
	input  wire [INS_W-1:0]        uop3_i,
	input  wire [PC_W-1:0]         grp_pc_i,
	output logic [MACRO_CNT_W-1:0] macro_cnt_o,
	output logic [MACRO_ENT_W-1:0] macro_ent_o,
	output logic                   grp_valid_o,
	output logic [PC_W-1:0]        grp_pc_o,
	output logic [INS_W-1:0]       ins0_o,
	output logic [INS_W-1:0]       ins1_o,
	output logic [INS_W-1:0]       ins2_o,
	output logic [INS_W-1:0]       ins3_o
);

	logic [LINE_W-1:0] line_q;
	logic [GRP_W-1:0]  half;
	logic [INS_W-1:0]  irq_ins;
	logic [INS_W-1:0]  slot [SLOTS];
	logic [INS_W-1:0]  uop [SLOTS];
	logic [INS_W-1:0]  grp [SLOTS];

	// Line register loads on the acknowledge edge
	always_ff @(posedge clk) begin
		if (line_load_i)
			line_q <= line_i;
	end

	assign uop[0] = uop0_i;
	assign uop[1] = uop1_i;
	assign uop[2] = uop2_i;
	assign uop[3] = uop3_i;

	// Interrupt word is OP_SYS with function, level and vector packed above it
	assign irq_ins = INS_W'(OP_SYS)
		| (INS_W'(irq_vec_i) << IRQ_VEC_LSB)
		| (INS_W'(irq_lvl_i) << IRQ_LVL_LSB)
		| (INS_W'(FN_IRQ) << FN_LSB);

	// ====================
	// Slot selection
	// ====================

	always_comb begin
		half = half_sel_i ? line_q[LINE_W-1:GRP_W] : line_q[GRP_W-1:0];
		// Slots ahead of a redirect target become no-ops
		for (int k = 0; k < SLOTS; k++) begin
			if (k < int'(skip_cnt_i))
				slot[k] = NOP_INS;
			else
				slot[k] = half[k*INS_W +: INS_W];
		end
		// A skipped slot 0 is a no-op, so it never starts a macro run
		if (slot[0][OPC_W-1:0] == OP_MACRO)
			macro_cnt_o = slot[0][MACRO_CNT_LSB +: MACRO_CNT_W];
		else
			macro_cnt_o = '0;
		macro_ent_o = slot[0][MACRO_ENT_LSB +: MACRO_ENT_W];
		for (int k = 0; k < SLOTS; k++) begin
			if (sel_uop_i)
				grp[k] = uop[k];
			else if (sel_irq_i)
				grp[k] = (k == 0) ? irq_ins : NOP_INS;
			else
				grp[k] = slot[k];
		end
	end

	// ====================
	// Output registers
	// ====================

	// Valid is a one-cycle mark per group and drops on a stalled cycle
	always_ff @(posedge clk) begin
		if (rst_i)
			grp_valid_o <= 1'b0;
		else
			grp_valid_o <= emit_i && en_i;
	end

	// Payload holds its value between groups
	always_ff @(posedge clk) begin
		if (emit_i && en_i) begin
			grp_pc_o <= grp_pc_i;
			ins0_o <= grp[0];
			ins1_o <= grp[1];
			ins2_o <= grp[2];
			ins3_o <= grp[3];
		end
	end

endmodule

`default_nettype wire

// File: extract_top.sv
`timescale 1ns/100ps
`default_nettype none

module extract_top import extract_pkg::*; (
	input  wire                  clk,
	input  wire                  rst_i,
	// Line source
	output logic                 line_req_o,
	output logic [PC_W-1:0]      line_addr_o,
	input  wire                  line_ack_i,
	input  wire [LINE_W-1:0]     line_i,
	// Interrupt source
	input  wire                  irq_req_i,
	input  wire [IRQ_VEC_W-1:0]  irq_vec_i,
	input  wire [IRQ_LVL_W-1:0]  irq_lvl_i,
	output logic                 irq_ack_o,
	// Branch-miss redirect
	input  wire                  redirect_i,
	input  wire [PC_W-1:0]       redirect_pc_i,
	// Group outputs
	input  wire                  en_i,
	output logic                 grp_valid_o,
	output logic [PC_W-1:0]      grp_pc_o,
	output logic [INS_W-1:0]     ins0_o,
	output logic [INS_W-1:0]     ins1_o,
	output logic [INS_W-1:0]     ins2_o,
	output logic [INS_W-1:0]     ins3_o
);

	// Controller to extractor
	logic                   line_load;
	logic                   emit;
	logic                   sel_irq;
	logic                   sel_uop;
	logic                   half_sel;
	logic [SLOT_IDX_W-1:0]  skip_cnt;
	logic [PC_W-1:0]        ctrl_pc;
	// Macro handoff
	logic                   uc_start;
	logic                   uc_busy;
	logic                   uc_last;
	logic [MACRO_CNT_W-1:0] macro_cnt;
	logic [MACRO_ENT_W-1:0] macro_ent;
	logic [INS_W-1:0]       uop0;
	logic [INS_W-1:0]       uop1;
	logic [INS_W-1:0]       uop2;
	logic [INS_W-1:0]       uop3;

	fetch_ctrl u_fetch_ctrl (
		.clk(clk), .rst_i(rst_i),
		.line_ack_i(line_ack_i), .irq_req_i(irq_req_i),
		.redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
		.en_i(en_i), .uc_busy_i(uc_busy), .uc_last_i(uc_last),
		.macro_cnt_i(macro_cnt),
		.line_req_o(line_req_o), .line_addr_o(line_addr_o),
		.irq_ack_o(irq_ack_o), .line_load_o(line_load),
		.emit_o(emit), .sel_irq_o(sel_irq), .sel_uop_o(sel_uop),
		.half_sel_o(half_sel), .skip_cnt_o(skip_cnt),
		.uc_start_o(uc_start), .grp_pc_o(ctrl_pc)
	);

	// Each emitted micro-op group is one step and a redirect cancels the run
	ucode_seq u_ucode_seq (
		.clk(clk), .rst_i(rst_i),
		.start_i(uc_start), .cancel_i(redirect_i), .step_i(sel_uop),
		.cnt_i(macro_cnt), .ent_i(macro_ent),
		.busy_o(uc_busy), .last_o(uc_last),
		.uop0_o(uop0), .uop1_o(uop1), .uop2_o(uop2), .uop3_o(uop3)
	);

	slot_extract u_slot_extract (
		.clk(clk), .rst_i(rst_i),
		.line_load_i(line_load), .line_i(line_i),
		.emit_i(emit), .en_i(en_i),
		.half_sel_i(half_sel), .skip_cnt_i(skip_cnt),
		.sel_irq_i(sel_irq), .sel_uop_i(sel_uop),
		.irq_vec_i(irq_vec_i), .irq_lvl_i(irq_lvl_i),
		.uop0_i(uop0), .uop1_i(uop1), .uop2_i(uop2), .uop3_i(uop3),
		.grp_pc_i(ctrl_pc),
		.macro_cnt_o(macro_cnt), .macro_ent_o(macro_ent),
		.grp_valid_o(grp_valid_o), .grp_pc_o(grp_pc_o),
		.ins0_o(ins0_o), .ins1_o(ins1_o), .ins2_o(ins2_o), .ins3_o(ins3_o)
	);

endmodule

`default_nettype wire

// File: extract_chk.sv
`timescale 1ns/100ps
`default_nettype none

module extract_chk import extract_pkg::*; (
	input wire            clk,
	input wire            rst_i,
	input wire            line_req_o,
	input wire [PC_W-1:0] line_addr_o,
	input wire            line_ack_i,
	input wire            irq_req_i,
	input wire            irq_ack_o,
	input wire            grp_valid_o
);

	// ====================
	// Line handshake
	// ====================

	// An open request keeps its address until the source answers
	a_req_hold: assert property (@(posedge clk) disable iff (rst_i)
		line_req_o && !line_ack_i |=> line_req_o && $stable(line_addr_o))
		else $error("line request dropped or line address moved before ack");

	// Request falls right after the acknowledge is seen
	a_req_drop: assert property (@(posedge clk) disable iff (rst_i)
		line_req_o && line_ack_i |=> !line_req_o)
		else $error("line request still high after ack");

	// No fresh request while the source still holds ack
	a_no_new_req: assert property (@(posedge clk) disable iff (rst_i)
		line_ack_i && !line_req_o |=> !line_req_o)
		else $error("new line request while ack is high");

	// ====================
	// Interrupt handshake
	// ====================

	// Ack only rises together with the interrupt group, for a request that was seen
	a_irq_ack_rise: assert property (@(posedge clk) disable iff (rst_i)
		$rose(irq_ack_o) |-> grp_valid_o && $past(irq_req_i))
		else $error("interrupt ack rose without an interrupt group");

	// Outputs come out of reset quiet
	a_reset_quiet: assert property (@(posedge clk)
		rst_i |=> !line_req_o && !irq_ack_o && !grp_valid_o)
		else $error("handshake or valid output high after reset");

endmodule

bind extract_top extract_chk u_extract_chk (
	.clk(clk),
	.rst_i(rst_i),
	.line_req_o(line_req_o),
	.line_addr_o(line_addr_o),
	.line_ack_i(line_ack_i),
	.irq_req_i(irq_req_i),
	.irq_ack_o(irq_ack_o),
	.grp_valid_o(grp_valid_o)
);

`default_nettype wire

// File: tb_extract.sv
`timescale 1ns/100ps
`default_nettype none

module tb_extract import extract_pkg::*; ();

	localparam int N_GROUPS = 400;
	localparam int CYCLE_LIMIT = 20 * N_GROUPS + 200;
	localparam int MEM_LINES = 64;
	// Interrupt source phases
	localparam int IRQ_IDLE = 0;
	localparam int IRQ_WAIT = 1;
	localparam int IRQ_HOLD = 2;
	localparam int IRQ_DROP = 3;

	logic                 clk;
	logic                 rst_i;
	logic                 line_ack_i;
	logic [LINE_W-1:0]    line_i;
	logic                 irq_req_i;
	logic [IRQ_VEC_W-1:0] irq_vec_i;
	logic [IRQ_LVL_W-1:0] irq_lvl_i;
	logic                 redirect_i;
	logic [PC_W-1:0]      redirect_pc_i;
	logic                 en_i;
	wire                  line_req_o;
	wire  [PC_W-1:0]      line_addr_o;
	wire                  irq_ack_o;
	wire                  grp_valid_o;
	wire  [PC_W-1:0]      grp_pc_o;
	wire  [INS_W-1:0]     ins0_o;
	wire  [INS_W-1:0]     ins1_o;
	wire  [INS_W-1:0]     ins2_o;
	wire  [INS_W-1:0]     ins3_o;

	logic [31:0]       lfsr_q;
	logic [LINE_W-1:0] mem [MEM_LINES];
	logic              drv_rst;
	int                ls_dly;
	logic              ls_acking;
	int                irq_state;
	int                irq_dly;
	// Reference model state
	logic [PC_W-1:0]        m_ptr;
	int                     m_skip;
	int                     m_uop_rem;
	int                     m_uop_step;
	logic [MACRO_ENT_W-1:0] m_uop_ent;
	logic                   irq_open;
	logic                   pend_irq;
	logic                   prev_en;
	logic                   prev_redir;
	logic                   prev_req;
	logic [PC_W-1:0]        exp_pc;
	logic [INS_W-1:0]       exp_ins [SLOTS];
	// Bookkeeping
	int cycle_cnt;
	int grp_cnt;
	int uop_grps;
	int irq_grps;
	int irq_reqs;
	int redir_cnt;
	int err_cnt;
	int other_cnt;

	extract_top u_extract_top (
		.clk(clk), .rst_i(rst_i),
		.line_req_o(line_req_o), .line_addr_o(line_addr_o),
		.line_ack_i(line_ack_i), .line_i(line_i),
		.irq_req_i(irq_req_i), .irq_vec_i(irq_vec_i), .irq_lvl_i(irq_lvl_i),
		.irq_ack_o(irq_ack_o),
		.redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
		.en_i(en_i), .grp_valid_o(grp_valid_o), .grp_pc_o(grp_pc_o),
		.ins0_o(ins0_o), .ins1_o(ins1_o), .ins2_o(ins2_o), .ins3_o(ins3_o)
	);

	always #2 clk = ~clk;

	// ====================
	// Random numbers
	// ====================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// Roughly one word in eight is a macro, its count and entry come from the random bits
	function automatic logic [INS_W-1:0] make_ins();
		if (rand_bits(3) == 32'd0)
			return (rand_bits(24) << 8) | 32'(OP_MACRO);
		return (rand_bits(24) << 8) | 32'(OP_ALU);
	endfunction

	// ====================
	// Expected encodings
	// ====================

	function automatic logic [INS_W-1:0] uop_word(input logic [5:0] ent, input int step,
		input int slot);
		return {12'd0, 2'(slot), 2'(step), ent, 2'b00, OP_UOP};
	endfunction

	function automatic logic [INS_W-1:0] irq_word(input logic [8:0] vec, input logic [2:0] lvl);
		return {8'd0, 4'd1, lvl, vec, OP_SYS};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Works out the next group from the model state and moves the model on
	task automatic predict_group();
		logic [LINE_W-1:0] line;
		exp_pc = m_ptr;
		if (m_uop_rem > 0) begin
			for (int k = 0; k < SLOTS; k++)
				exp_ins[k] = uop_word(m_uop_ent, m_uop_step, k);
			m_uop_step++;
			m_uop_rem--;
			uop_grps++;
			// Past the macro group once its run is done
			if (m_uop_rem == 0)
				m_ptr = m_ptr + PC_W'(16);
		end else if (pend_irq) begin
			exp_ins[0] = irq_word(irq_vec_i, irq_lvl_i);
			for (int k = 1; k < SLOTS; k++)
				exp_ins[k] = '0;
			irq_open = 1'b0;
			irq_grps++;
		end else begin
			line = mem[m_ptr[10:5]];
			for (int k = 0; k < SLOTS; k++) begin
				if (k < m_skip)
					exp_ins[k] = '0;
				else
					exp_ins[k] = line[(int'(m_ptr[4]) * SLOTS + k) * INS_W +: INS_W];
			end
			m_skip = 0;
			if (exp_ins[0][7:0] == OP_MACRO && exp_ins[0][9:8] != 2'd0) begin
				m_uop_rem = int'(exp_ins[0][9:8]);
				m_uop_step = 0;
				m_uop_ent = exp_ins[0][15:10];
			end else begin
				m_ptr = m_ptr + PC_W'(16);
			end
		end
	endtask

	// ====================
	// Source models
	// ====================

	// Four-phase line source with a short random wait on each phase
	task automatic drive_line_source();
		if (!ls_acking && line_req_o) begin
			if (ls_dly == 0) begin
				line_ack_i = 1'b1;
				line_i = mem[line_addr_o[10:5]];
				ls_dly = int'(rand_bits(2));
				ls_acking = 1'b1;
			end else begin
				ls_dly--;
			end
		end else if (ls_acking && !line_req_o) begin
			if (ls_dly == 0) begin
				line_ack_i = 1'b0;
				line_i = '0;
				ls_dly = int'(rand_bits(2));
				ls_acking = 1'b0;
			end else begin
				ls_dly--;
			end
		end
	endtask

	task automatic drive_irq_source();
		case (irq_state)
			IRQ_IDLE: begin
				if (irq_dly == 0) begin
					irq_req_i = 1'b1;
					irq_vec_i = IRQ_VEC_W'(rand_bits(9));
					irq_lvl_i = IRQ_LVL_W'(rand_bits(3));
					irq_open = 1'b1;
					irq_reqs++;
					irq_state = IRQ_WAIT;
				end else begin
					irq_dly--;
				end
			end
			IRQ_WAIT: begin
				if (irq_ack_o) begin
					irq_dly = int'(rand_bits(2));
					irq_state = IRQ_HOLD;
				end
			end
			IRQ_HOLD: begin
				if (irq_dly == 0) begin
					irq_req_i = 1'b0;
					irq_state = IRQ_DROP;
				end else begin
					irq_dly--;
				end
			end
			default: begin
				if (!irq_ack_o) begin
					irq_dly = int'(rand_bits(5)) + 4;
					irq_state = IRQ_IDLE;
				end
			end
		endcase
	endtask

	// Inputs change half a nanosecond after the edge
	always @(posedge clk) begin
		drv_rst = rst_i;
		#0.5;
		if (!drv_rst) begin
			en_i = (rand_bits(2) != 32'd0);
			redirect_i = (rand_bits(6) == 32'd0);
			if (redirect_i)
				redirect_pc_i = PC_W'(rand_bits(11));
			drive_line_source();
			drive_irq_source();
		end
	end

	// ====================
	// Monitor
	// ====================

	always @(posedge clk) begin
		if (rst_i) begin
			m_ptr = '0;
			m_skip = 0;
			m_uop_rem = 0;
			m_uop_step = 0;
			m_uop_ent = '0;
			irq_open = 1'b0;
			pend_irq = 1'b0;
			prev_en = 1'b1;
			prev_redir = 1'b0;
			prev_req = 1'b0;
		end else begin
			cycle_cnt++;
			// A stalled or redirected edge emits nothing
			if (!prev_en || prev_redir)
				check_value(32'(grp_valid_o), 32'd0, "grp_valid_o after stall or redirect");
			if (grp_valid_o) begin
				predict_group();
				grp_cnt++;
			end
			// Outputs must match the latest group whether fresh or held
			if (grp_cnt > 0) begin
				check_value(32'(grp_pc_o), 32'(exp_pc), "grp_pc_o");
				check_value(ins0_o, exp_ins[0], "ins0_o");
				check_value(ins1_o, exp_ins[1], "ins1_o");
				check_value(ins2_o, exp_ins[2], "ins2_o");
				check_value(ins3_o, exp_ins[3], "ins3_o");
			end
			// A fresh request asks for the line that holds the next group
			if (line_req_o && !prev_req)
				check_value(32'(line_addr_o), 32'(m_ptr & ~PC_W'(31)), "line_addr_o");
			if (redirect_i) begin
				m_ptr = redirect_pc_i & ~PC_W'(15);
				m_skip = int'(redirect_pc_i[3:2]);
				m_uop_rem = 0;
				redir_cnt++;
			end
			// Seen by the DUT on this edge, so it decides the group that shows up next
			pend_irq = irq_open;
			prev_en = en_i;
			prev_redir = redirect_i;
			prev_req = line_req_o;
		end
	end

	initial begin
		clk = 1'b0;
		rst_i = 1'b1;
		line_ack_i = 1'b0;
		line_i = '0;
		irq_req_i = 1'b0;
		irq_vec_i = '0;
		irq_lvl_i = '0;
		redirect_i = 1'b0;
		redirect_pc_i = '0;
		en_i = 1'b0;
		ls_dly = 0;
		ls_acking = 1'b0;
		irq_state = IRQ_IDLE;
		irq_dly = 8;
		lfsr_q = 32'hd0d0_3259;
		for (int a = 0; a < MEM_LINES; a++) begin
			for (int k = 0; k < 2 * SLOTS; k++)
				mem[a][k * INS_W +: INS_W] = make_ins();
		end
		repeat (2) @(posedge clk);
		#0.5;
		rst_i = 1'b0;
		while (grp_cnt < N_GROUPS && cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			#1;
		end
		if (grp_cnt < N_GROUPS) begin
			other_cnt++;
			$display("Timeout: %0d of %0d groups after %0d cycles", grp_cnt, N_GROUPS, cycle_cnt);
		end
		// A request still open at the end has had no group yet
		if (irq_grps != irq_reqs - int'(irq_open)) begin
			other_cnt++;
			$display("Interrupt count wrong: %0d requests but %0d interrupt groups",
				irq_reqs, irq_grps);
		end
		$display("Done: %0d groups, %0d uop, %0d irq, %0d redirects, %0d value errors, %0d other errors",
			grp_cnt, uop_grps, irq_grps, redir_cnt, err_cnt, other_cnt);
		if (err_cnt == 0 && other_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
extract_pkg.sv
fetch_ctrl.sv
ucode_seq.sv
slot_extract.sv
extract_top.sv
extract_chk.sv
tb_extract.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the extract stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f filelist.f --top-module tb_extract -o tb_extract_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/tb_extract_sim > "$SIM_LOG" 2>&1
run_status=$?
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status, see $SIM_LOG"
	exit 1
fi

if grep -q "Simulation PASSED" "$SIM_LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL, see $SIM_LOG"
	exit 1
fi
